/* common/rvDefs_defs.svh */
// core parameters: data width, register count, reset PC, NOP encoding
`ifndef RVDEFS_DEFS_SVH
`define RVDEFS_DEFS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// ADDI x0,x0,0
// fills squashed IF/ID slots and the reset state of IF/ID
`define RV_NOP_INST 32'h0000_0013

`endif

/* common/rvPkg.sv */
// word, register and ALU types, pipeline-register structs, forwarding mux
`default_nettype none
`include "rvDefs_defs.svh"

package rvPkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] regAddr_t;
    typedef logic [`RV_XLEN-3:0] wordAddr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } aluOp_t;

    // MEM has priority over WB
    typedef enum logic [1:0] {FWD_NONE, FWD_WB, FWD_MEM} fwdSel_t;

    // aluMode encodings
    localparam logic [1:0] MODE_ADDR = 2'd0;
    localparam logic [1:0] MODE_CMP  = 2'd1;
    localparam logic [1:0] MODE_REG  = 2'd2;
    localparam logic [1:0] MODE_IMM  = 2'd3;

    // ====================
    // pipeline registers
    // ====================
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrcImm;
        logic isJump;
        logic [1:0] aluMode;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t rs1Data;
        word_t rs2Data;
        word_t imm;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        logic [2:0] funct3;
        logic funct7b5;
    } idEx_t;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        word_t result;
        word_t storeData;
        regAddr_t rd;
    } exMem_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        word_t result;
        word_t loadData;
        regAddr_t rd;
    } memWb_t;

    // operand select shared by decode and execute
    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal,
                                     word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/regFile.sv */
// register file with two asynchronous reads, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none
`include "rvDefs_defs.svh"

module regFile (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   we,
    input  wire rvPkg::regAddr_t  wAddr,
    input  wire rvPkg::word_t     wData,
    input  wire rvPkg::regAddr_t  rAddrA,
    input  wire rvPkg::regAddr_t  rAddrB,
    output rvPkg::word_t          rDataA,
    output rvPkg::word_t          rDataB
);
    import rvPkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // same-cycle write is not visible here, WB forwarding covers it
    assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
    assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

`default_nettype wire

/* hw/hazardUnit.sv */
// load-use and branch-operand stalls, forward selects for decode and execute
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire rvPkg::regAddr_t  idRs1,
    input  wire rvPkg::regAddr_t  idRs2,
    input  wire                   usesRs1ForControl,
    input  wire rvPkg::idEx_t     idEx,
    input  wire rvPkg::exMem_t    exMem,
    input  wire rvPkg::memWb_t    memWb,
    output logic                  stallId,
    output rvPkg::fwdSel_t        fwdIdA,
    output rvPkg::fwdSel_t        fwdIdB,
    output rvPkg::fwdSel_t        fwdExA,
    output rvPkg::fwdSel_t        fwdExB
);
    import rvPkg::*;

    logic loadUse;
    logic ctrlHazard;

    function automatic fwdSel_t pickFwd(regAddr_t rs, regAddr_t memRd, logic memEn,
                                        regAddr_t wbRd, logic wbEn);
        if (rs == '0) return FWD_NONE;
        if (memEn && memRd == rs) return FWD_MEM;
        if (wbEn && wbRd == rs) return FWD_WB;
        return FWD_NONE;
    endfunction

    function automatic logic hits(regAddr_t rd, regAddr_t a, regAddr_t b);
        return (rd != '0) && (rd == a || rd == b);
    endfunction

    // a load in MEM only carries its address, decode must not take it
    assign fwdIdA = pickFwd(idRs1, exMem.rd, exMem.regWrite && !exMem.memRead,
                            memWb.rd, memWb.regWrite);
    assign fwdIdB = pickFwd(idRs2, exMem.rd, exMem.regWrite && !exMem.memRead,
                            memWb.rd, memWb.regWrite);
    assign fwdExA = pickFwd(idEx.rs1, exMem.rd, exMem.regWrite, memWb.rd, memWb.regWrite);
    assign fwdExB = pickFwd(idEx.rs2, exMem.rd, exMem.regWrite, memWb.rd, memWb.regWrite);

    assign loadUse = idEx.ctrl.memRead && hits(idEx.rd, idRs1, idRs2);

    // branch and JALR compare in decode, so producers still in EX must drain
    assign ctrlHazard = usesRs1ForControl &&
                        ((idEx.ctrl.regWrite && hits(idEx.rd, idRs1, idRs2)) ||
                         (exMem.memRead && hits(exMem.rd, idRs1, idRs2)));

    assign stallId = loadUse || ctrlHazard;

endmodule

`default_nettype wire

/* hw/pipeline/fetchStage.sv */
// PC register, next-PC select, IF/ID register with squash and hold
`timescale 1ns/1ps
`default_nettype none
`include "rvDefs_defs.svh"

module fetchStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   freeze,
    input  wire                   stallId,
    input  wire                   redirect,
    input  wire rvPkg::word_t     target,
    output rvPkg::wordAddr_t      imemAddr,
    input  wire rvPkg::word_t     imemData,
    output rvPkg::word_t          ifPc,
    output rvPkg::word_t          ifInst
);
    import rvPkg::*;

    word_t pc;
    word_t pcNext;
    logic hold;

    assign hold = freeze || stallId;
    assign imemAddr = pc[`RV_XLEN-1:2];

    always_comb begin
        if (redirect) begin
            pcNext = target;
        end else begin
            pcNext = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `RV_RESET_PC;
            ifPc   <= `RV_RESET_PC;
            ifInst <= `RV_NOP_INST;
        end else if (!hold) begin
            pc   <= pcNext;
            ifPc <= pc;
            // wrong-path word gets squashed
            ifInst <= redirect ? `RV_NOP_INST : imemData;
        end
    end

endmodule

`default_nettype wire

/* hw/pipeline/decodeStage.sv */
// instruction decode, immediates, operand forwarding, branch resolve, ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   freeze,
    input  wire                   stallId,
    input  wire rvPkg::word_t     ifPc,
    input  wire rvPkg::word_t     ifInst,
    output rvPkg::regAddr_t       rs1,
    output rvPkg::regAddr_t       rs2,
    input  wire rvPkg::word_t     rs1Data,
    input  wire rvPkg::word_t     rs2Data,
    input  wire rvPkg::fwdSel_t   fwdA,
    input  wire rvPkg::fwdSel_t   fwdB,
    input  wire rvPkg::word_t     memResult,
    input  wire rvPkg::word_t     wbValue,
    output logic                  redirect,
    output rvPkg::word_t          target,
    output rvPkg::idEx_t          idEx,
    output logic                  usesRs1ForControl
);
    import rvPkg::*;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    ctrl_t ctrl;
    word_t imm;
    word_t immI;
    word_t opA;
    word_t opB;
    logic isBranch;
    logic isJal;
    logic isJalr;
    logic taken;

    assign rs1 = ifInst[19:15];
    assign rs2 = ifInst[24:20];
    assign isBranch = (ifInst[6:0] == OP_BRANCH);
    assign isJal = (ifInst[6:0] == OP_JAL);
    assign isJalr = (ifInst[6:0] == OP_JALR);
    assign immI = {{20{ifInst[31]}}, ifInst[31:20]};

    // ====================
    // control and immediates
    // ====================
    always_comb begin
        ctrl = '0;
        imm = immI;
        case (ifInst[6:0])
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluMode = MODE_REG;
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluMode = MODE_IMM;
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm = {{20{ifInst[31]}}, ifInst[31:25], ifInst[11:7]};
            end
            OP_BRANCH: begin
                ctrl.aluMode = MODE_CMP;
                imm = {{19{ifInst[31]}}, ifInst[31], ifInst[7], ifInst[30:25],
                       ifInst[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.isJump = 1'b1;
                imm = {{11{ifInst[31]}}, ifInst[31], ifInst[19:12], ifInst[20],
                       ifInst[30:21], 1'b0};
            end
            OP_JALR: begin
                ctrl.regWrite = 1'b1;
                ctrl.isJump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // ====================
    // branch and jump resolve
    // ====================
    assign opA = fwdMux(fwdA, rs1Data, memResult, wbValue);
    assign opB = fwdMux(fwdB, rs2Data, memResult, wbValue);

    // funct3 bit 0 turns BEQ into BNE
    assign taken = (opA == opB) ^ ifInst[12];
    assign target = isJalr ? ((opA + imm) & ~word_t'(1)) : (ifPc + imm);
    assign redirect = !stallId && (isJal || isJalr || (isBranch && taken));
    assign usesRs1ForControl = isBranch || isJalr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!freeze) begin
            // stalled slot leaves as a bubble
            idEx.ctrl     <= stallId ? ctrl_t'('0) : ctrl;
            idEx.pc       <= ifPc;
            idEx.rs1Data  <= opA;
            idEx.rs2Data  <= opB;
            idEx.imm      <= imm;
            idEx.rs1      <= rs1;
            idEx.rs2      <= rs2;
            idEx.rd       <= ifInst[11:7];
            idEx.funct3   <= ifInst[14:12];
            idEx.funct7b5 <= ifInst[30];
        end
    end

endmodule

`default_nettype wire

/* hw/pipeline/executeStage.sv */
// ALU control, ALU, operand forwarding, link select, EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   freeze,
    input  wire rvPkg::idEx_t     idEx,
    input  wire rvPkg::fwdSel_t   fwdA,
    input  wire rvPkg::fwdSel_t   fwdB,
    input  wire rvPkg::word_t     memResult,
    input  wire rvPkg::word_t     wbValue,
    output rvPkg::exMem_t         exMem
);
    import rvPkg::*;

    aluOp_t aluOp;
    word_t opA;
    word_t opB;
    word_t rs2Fwd;
    word_t aluOut;

    // funct7 bit 5 selects SUB only in register form, SRA in both forms
    always_comb begin
        aluOp = ALU_ADD;
        if (idEx.ctrl.aluMode == MODE_CMP) begin
            aluOp = ALU_SUB;
        end else if (idEx.ctrl.aluMode != MODE_ADDR) begin
            case (idEx.funct3)
                3'b000: begin
                    if (idEx.ctrl.aluMode == MODE_REG && idEx.funct7b5) aluOp = ALU_SUB;
                end
                3'b001: aluOp = ALU_SLL;
                3'b010: aluOp = ALU_SLT;
                3'b100: aluOp = ALU_XOR;
                3'b101: aluOp = idEx.funct7b5 ? ALU_SRA : ALU_SRL;
                3'b110: aluOp = ALU_OR;
                3'b111: aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    assign opA = fwdMux(fwdA, idEx.rs1Data, memResult, wbValue);
    assign rs2Fwd = fwdMux(fwdB, idEx.rs2Data, memResult, wbValue);
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rs2Fwd;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluOut = opA - opB;
            ALU_SLT: aluOut = word_t'($signed(opA) < $signed(opB));
            ALU_XOR: aluOut = opA ^ opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_AND: aluOut = opA & opB;
            ALU_SLL: aluOut = opA << opB[4:0];
            ALU_SRL: aluOut = opA >> opB[4:0];
            ALU_SRA: aluOut = word_t'($signed(opA) >>> opB[4:0]);
            default: aluOut = opA + opB;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!freeze) begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            // link value here so EX/MEM forwarding sees it
            exMem.result    <= idEx.ctrl.isJump ? idEx.pc + word_t'(4) : aluOut;
            exMem.storeData <= rs2Fwd;
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

/* hw/pipeline/memStage.sv */
// data-port request, MEM/WB register, writeback select
`timescale 1ns/1ps
`default_nettype none
`include "rvDefs_defs.svh"

module memStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   freeze,
    input  wire rvPkg::exMem_t    exMem,
    output logic                  dmemRead,
    output logic                  dmemWrite,
    output rvPkg::wordAddr_t      dmemAddr,
    output rvPkg::word_t          dmemWdata,
    input  wire rvPkg::word_t     dmemRdata,
    output rvPkg::memWb_t         memWb,
    output rvPkg::word_t          wbValue
);
    import rvPkg::*;

    // port outputs come straight from EX/MEM, so they hold while frozen
    assign dmemRead  = exMem.memRead;
    assign dmemWrite = exMem.memWrite;
    assign dmemAddr  = exMem.result[`RV_XLEN-1:2];
    assign dmemWdata = exMem.storeData;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.result   <= exMem.result;
            memWb.loadData <= dmemRdata;
            memWb.rd       <= exMem.rd;
        end
    end

    assign wbValue = memWb.memToReg ? memWb.loadData : memWb.result;

endmodule

`default_nettype wire

/* hw/rvCore.sv */
// pipeline top: stage instances, register file, hazard unit, memory ports, freeze
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  wire                   clk,
    input  wire                   rst_n,
    output rvPkg::wordAddr_t      imemAddr,
    input  wire rvPkg::word_t     imemData,
    input  wire                   imemStall,
    output logic                  dmemRead,
    output logic                  dmemWrite,
    output rvPkg::wordAddr_t      dmemAddr,
    output rvPkg::word_t          dmemWdata,
    input  wire rvPkg::word_t     dmemRdata,
    input  wire                   dmemStall
);
    import rvPkg::*;

    logic freeze;
    logic stallId;
    logic redirect;
    logic usesRs1ForControl;
    word_t target;
    word_t ifPc;
    word_t ifInst;
    word_t rs1Data;
    word_t rs2Data;
    word_t wbValue;
    regAddr_t rs1;
    regAddr_t rs2;
    fwdSel_t fwdIdA;
    fwdSel_t fwdIdB;
    fwdSel_t fwdExA;
    fwdSel_t fwdExB;
    idEx_t idEx;
    exMem_t exMem;
    memWb_t memWb;

    // any memory stall freezes every stage
    assign freeze = imemStall || dmemStall;

    fetchStage fetch_i (
        .clk, .rst_n, .freeze, .stallId, .redirect, .target,
        .imemAddr, .imemData, .ifPc, .ifInst
    );

    decodeStage decode_i (
        .clk, .rst_n, .freeze, .stallId, .ifPc, .ifInst, .rs1, .rs2,
        .rs1Data, .rs2Data, .fwdA(fwdIdA), .fwdB(fwdIdB),
        .memResult(exMem.result), .wbValue, .redirect, .target, .idEx,
        .usesRs1ForControl
    );

    executeStage execute_i (
        .clk, .rst_n, .freeze, .idEx, .fwdA(fwdExA), .fwdB(fwdExB),
        .memResult(exMem.result), .wbValue, .exMem
    );

    memStage mem_i (
        .clk, .rst_n, .freeze, .exMem, .dmemRead, .dmemWrite, .dmemAddr,
        .dmemWdata, .dmemRdata, .memWb, .wbValue
    );

    regFile regs_i (
        .clk, .rst_n,
        .we(memWb.regWrite && !freeze), .wAddr(memWb.rd), .wData(wbValue),
        .rAddrA(rs1), .rAddrB(rs2), .rDataA(rs1Data), .rDataB(rs2Data)
    );

    hazardUnit hazard_i (
        .idRs1(rs1), .idRs2(rs2), .usesRs1ForControl, .idEx, .exMem, .memWb,
        .stallId, .fwdIdA, .fwdIdB, .fwdExA, .fwdExB
    );

endmodule

`default_nettype wire

/* tb/rvCore_asserts.sv */
// concurrent checks on freeze hold, port exclusivity and redirect squash, bound into rvCore
`timescale 1ns/1ps
`default_nettype none
`include "rvDefs_defs.svh"

module rvCoreAsserts (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   imemStall,
    input  wire                   dmemStall,
    input  wire rvPkg::wordAddr_t imemAddr,
    input  wire                   dmemRead,
    input  wire                   dmemWrite,
    input  wire rvPkg::wordAddr_t dmemAddr,
    input  wire rvPkg::word_t     dmemWdata,
    input  wire                   redirect,
    input  wire rvPkg::word_t     ifInst
);

    logic frozen;

    assign frozen = imemStall || dmemStall;

    // frozen pipe keeps the memory requests steady
    dataPortHolds: assert property (@(posedge clk) disable iff (!rst_n)
        frozen |=> $stable({dmemRead, dmemWrite, dmemAddr, dmemWdata}))
        else $error("data port outputs changed while a memory port stalled");

    fetchAddrHolds: assert property (@(posedge clk) disable iff (!rst_n)
        frozen |=> $stable(imemAddr))
        else $error("instruction address changed while a memory port stalled");

    readWriteExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmemRead && dmemWrite))
        else $error("dmemRead and dmemWrite high together");

    // wrong-path word never reaches decode
    redirectSquash: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect && !frozen) |=> (ifInst == `RV_NOP_INST))
        else $error("IF/ID does not hold a NOP after a redirect");

endmodule

`default_nettype wire

/* tb/tbRvCore.sv */
// rvCore testbench with memory models, random stalls, program table, store checks and report
`timescale 1ns/1ps
`default_nettype none
`include "rvDefs_defs.svh"

module tbRvCore;
    import rvPkg::*;

    localparam int MEM_WORDS = 64;
    localparam wordAddr_t MARKER_WADDR = 30'd63;
    localparam logic [6:0] OP_R = 7'h33;
    localparam logic [6:0] OP_I = 7'h13;
    localparam logic [6:0] OP_LOAD = 7'h03;
    localparam logic [6:0] OP_JALR = 7'h67;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic imemStall = 1'b0;
    logic dmemStall = 1'b0;
    logic dmemRead;
    logic dmemWrite;
    wordAddr_t imemAddr;
    wordAddr_t dmemAddr;
    word_t imemData;
    word_t dmemWdata;
    word_t dmemRdata;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    // ====================
    // test table
    // ====================
    string testName [$];
    int progStart [$];
    int progLen [$];
    bit stallEn [$];
    int expStart [$];
    int expCount [$];
    word_t progWords [$];
    wordAddr_t expAddr [$];
    word_t expData [$];

    int seed = 75;
    int cur = 0;
    int storeIdx = 0;
    int testErrors = 0;
    int totalErrors = 0;
    int testsPassed = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int nextOff = 0;
    bit stallOn = 1'b0;
    bit testDone = 1'b0;

    rvCore rvCore_i (
        .clk, .rst_n, .imemAddr, .imemData, .imemStall, .dmemRead, .dmemWrite,
        .dmemAddr, .dmemWdata, .dmemRdata, .dmemStall
    );

    bind rvCore rvCoreAsserts coreAsserts_i (
        .clk, .rst_n, .imemStall, .dmemStall, .imemAddr, .dmemRead, .dmemWrite,
        .dmemAddr, .dmemWdata, .redirect, .ifInst
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // read data valid in the same cycle
    assign imemData = imem[imemAddr[5:0]];
    // load data only while a read is requested
    assign dmemRdata = dmemRead ? dmem[dmemAddr[5:0]] : '0;

    always @(posedge clk) begin
        if (rst_n && stallOn) begin
            imemStall <= ($random(seed) & 3) == 0;
            dmemStall <= ($random(seed) & 3) == 0;
        end else begin
            imemStall <= 1'b0;
            dmemStall <= 1'b0;
        end
    end

    // ====================
    // instruction encoders
    // ====================
    function automatic word_t rType(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_R};
    endfunction

    function automatic word_t iType(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    // SW rs2, imm(x0)
    function automatic word_t sType(int imm, int rs2);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'd0, 3'b010, i[4:0], 7'h23};
    endfunction

    function automatic word_t bType(int imm, int rs2, int rs1, logic [2:0] f3);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'h63};
    endfunction

    function automatic word_t jType(int imm, int rd);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'h6F};
    endfunction

    // data memory contents before any store
    function automatic word_t fillWord(int idx);
        return 32'h5A00_0000 ^ (word_t'(idx) * 32'h0001_0101);
    endfunction

    // ====================
    // table building
    // ====================
    task automatic newTest(string name, bit stalls);
        testName.push_back(name);
        progStart.push_back(progWords.size());
        progLen.push_back(0);
        stallEn.push_back(stalls);
        expStart.push_back(expData.size());
        expCount.push_back(0);
        nextOff = 0;
    endtask

    task automatic addInst(word_t inst);
        progWords.push_back(inst);
        progLen[progLen.size()-1] += 1;
    endtask

    // byte address of the next instruction in the current program
    function automatic word_t nextPc();
        return word_t'(4 * progLen[progLen.size()-1]);
    endfunction

    task automatic storeReg(int rs, int off, word_t val);
        addInst(sType(off, rs));
        expAddr.push_back(wordAddr_t'(off / 4));
        expData.push_back(val);
        expCount[expCount.size()-1] += 1;
    endtask

    // result in x3 goes to the next free slot
    task automatic aluCheck(word_t inst, word_t val);
        addInst(inst);
        storeReg(3, nextOff, val);
        nextOff += 4;
    endtask

    task automatic endWithMarker();
        addInst(sType(252, 0));
    endtask

    task automatic fwdProgram(string name, bit stalls);
        word_t v1;
        word_t v2;
        v1 = 32'd5;
        v2 = v1 + 32'd7;
        newTest(name, stalls);
        addInst(iType(5, 0, 3'b000, 1, OP_I));
        // distance 1 on x1
        addInst(iType(7, 1, 3'b000, 2, OP_I));
        aluCheck(rType(7'h00, 1, 2, 3'b000, 3), v2 + v1);
        aluCheck(rType(7'h20, 2, 3, 3'b000, 3), (v2 + v1) - v2);
        addInst(iType(2, 3, 3'b001, 4, OP_I));
        aluCheck(rType(7'h00, 3, 4, 3'b000, 3), (v1 << 2) + v1);
        endWithMarker();
    endtask

    task automatic buildTable();
        word_t a;
        word_t b;
        word_t link;
        a = word_t'(-7);
        b = 32'd35;
        newTest("aluOps", 1'b0);
        addInst(iType(-7, 0, 3'b000, 1, OP_I));
        addInst(iType(35, 0, 3'b000, 2, OP_I));
        aluCheck(rType(7'h00, 2, 1, 3'b000, 3), a + b);
        aluCheck(rType(7'h20, 2, 1, 3'b000, 3), a - b);
        aluCheck(rType(7'h00, 2, 1, 3'b010, 3), word_t'($signed(a) < $signed(b)));
        aluCheck(rType(7'h00, 2, 1, 3'b100, 3), a ^ b);
        aluCheck(rType(7'h00, 2, 1, 3'b110, 3), a | b);
        aluCheck(rType(7'h00, 2, 1, 3'b111, 3), a & b);
        // shift amount is rs2[4:0], so 35 shifts by 3
        aluCheck(rType(7'h00, 2, 1, 3'b001, 3), a << b[4:0]);
        aluCheck(rType(7'h00, 2, 1, 3'b101, 3), a >> b[4:0]);
        aluCheck(rType(7'h20, 2, 1, 3'b101, 3), word_t'($signed(a) >>> b[4:0]));
        aluCheck(iType(100, 1, 3'b000, 3, OP_I), a + 32'd100);
        aluCheck(iType(-8, 1, 3'b010, 3, OP_I), word_t'($signed(a) < -32'sd8));
        aluCheck(iType(12'h555, 1, 3'b100, 3, OP_I), a ^ 32'h555);
        aluCheck(iType(-256, 1, 3'b110, 3, OP_I), a | word_t'(-256));
        aluCheck(iType(12'h0F0, 1, 3'b111, 3, OP_I), a & 32'h0F0);
        aluCheck(iType(4, 1, 3'b001, 3, OP_I), a << 4);
        aluCheck(iType(28, 1, 3'b101, 3, OP_I), a >> 28);
        aluCheck(iType(12'h402, 1, 3'b101, 3, OP_I), word_t'($signed(a) >>> 2));
        endWithMarker();

        fwdProgram("forwarding", 1'b0);

        newTest("loadUse", 1'b0);
        addInst(iType(77, 0, 3'b000, 1, OP_I));
        storeReg(1, 128, 32'd77);
        addInst(iType(128, 0, 3'b010, 2, OP_LOAD));
        aluCheck(rType(7'h00, 2, 2, 3'b000, 3), 32'd77 + 32'd77);
        addInst(iType(160, 0, 3'b010, 3, OP_LOAD));
        storeReg(3, 132, fillWord(160 / 4));
        endWithMarker();

        // the stores at 200 and up sit on skipped paths
        newTest("branches", 1'b0);
        addInst(iType(3, 0, 3'b000, 1, OP_I));
        addInst(iType(3, 0, 3'b000, 2, OP_I));
        addInst(bType(8, 2, 1, 3'b000));
        addInst(sType(200, 1));
        addInst(bType(8, 2, 1, 3'b001));
        aluCheck(iType(11, 0, 3'b000, 3, OP_I), 32'd11);
        addInst(iType(128, 0, 3'b010, 4, OP_LOAD));
        addInst(bType(8, 0, 4, 3'b001));
        addInst(sType(204, 4));
        addInst(bType(8, 0, 4, 3'b000));
        aluCheck(iType(22, 0, 3'b000, 3, OP_I), 32'd22);
        endWithMarker();

        newTest("jumps", 1'b0);
        link = nextPc() + 32'd4;
        addInst(jType(12, 1));
        addInst(sType(200, 0));
        addInst(sType(204, 0));
        storeReg(1, 128, link);
        addInst(iType(35, 0, 3'b000, 5, OP_I));
        link = nextPc() + 32'd4;
        // odd sum 37 has bit 0 cleared and lands on 36
        addInst(iType(2, 5, 3'b000, 6, OP_JALR));
        addInst(sType(208, 0));
        addInst(sType(212, 0));
        addInst(sType(216, 0));
        storeReg(6, 132, link);
        endWithMarker();

        fwdProgram("forwardingStalls", 1'b1);
    endtask

    // ====================
    // store monitor
    // ====================
    task automatic checkStore(wordAddr_t addr, word_t data);
        int k;
        k = expStart[cur] + storeIdx;
        assert (storeIdx < expCount[cur]) else begin
            $display("%s: unexpected extra store of %h to word %0d", testName[cur], data, addr);
            testErrors++;
        end
        if (storeIdx < expCount[cur]) begin
            assert (addr == expAddr[k]) else begin
                $display("Mismatch %s store %0d address: expected %0d, actual %0d",
                         testName[cur], storeIdx, expAddr[k], addr);
                testErrors++;
            end
            assert (data == expData[k]) else begin
                $display("Mismatch %s store %0d data: expected %h, actual %h",
                         testName[cur], storeIdx, expData[k], data);
                testErrors++;
            end
        end
        storeIdx++;
    endtask

    // stalls and port outputs are steady at the falling edge
    always @(negedge clk) begin
        if (rst_n && !testDone && dmemWrite && !imemStall && !dmemStall) begin
            if (dmemAddr == MARKER_WADDR) begin
                testDone = 1'b1;
            end else begin
                checkStore(dmemAddr, dmemWdata);
            end
            dmem[dmemAddr[5:0]] = dmemWdata;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: %s did not reach its marker store within %0d cycles",
                     testName[cur], cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic runTest(int t);
        @(posedge clk);
        rst_n <= 1'b0;
        stallOn <= stallEn[t];
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < progLen[t]) ? progWords[progStart[t] + i] : `RV_NOP_INST;
            dmem[i] = fillWord(i);
        end
        cur = t;
        storeIdx = 0;
        testErrors = 0;
        testDone = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (!testDone) @(posedge clk);
        assert (storeIdx == expCount[t]) else begin
            $display("%s: marker store came after %0d of %0d expected stores",
                     testName[t], storeIdx, expCount[t]);
            testErrors++;
        end
        if (testErrors == 0) begin
            testsPassed++;
            $display("PASS %s: %0d stores matched", testName[t], storeIdx);
        end else begin
            $display("FAIL %s: %0d errors", testName[t], testErrors);
        end
        totalErrors += testErrors;
    endtask

    initial begin
        buildTable();
        cycleLimit = 20 * progWords.size();
        for (int t = 0; t < testName.size(); t++) begin
            runTest(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d check errors", testName.size(),
                 testsPassed, testName.size() - testsPassed, totalErrors);
        if (totalErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/rvPkg.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/pipeline/fetchStage.sv
hw/pipeline/decodeStage.sv
hw/pipeline/executeStage.sv
hw/pipeline/memStage.sv
hw/rvCore.sv
tb/rvCore_asserts.sv
tb/tbRvCore.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbRvCore
FILELIST = sources.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
